// File: source/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;     // data or address word.
    typedef logic [4:0]  reg_idx_t;  // register index.
    typedef logic [31:0] inst_t;     // raw instruction.
    typedef logic [6:0]  opcode_t;

    // operations the alu performs.
    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B    // lui takes the immediate as is.
    } alu_op_t;

    // major opcodes of the supported subset.
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // addi x0, x0, 0.
    localparam inst_t NOP_INST = 32'h0000_0013;

endpackage

`default_nettype wire

// File: source/rv_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// decode to alu stage register.
interface rv_dec_if;
    import rv_pkg::*;

    logic     valid;
    alu_op_t  op;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;
    logic     use_imm;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    reg_idx_t rd;        // zero when nothing is written.
    word_t    pc;
    logic     sup;

    modport src (output valid, op, rs1_val, rs2_val, imm, use_imm, is_load, is_store,
                        is_branch, rd, pc, sup);
    modport sink (input valid, op, rs1_val, rs2_val, imm, use_imm, is_load, is_store,
                        is_branch, rd, pc, sup);
    modport mon (input valid, rd, is_load);
endinterface

// alu to mem stage register.
interface rv_exe_if;
    import rv_pkg::*;

    logic     valid;
    word_t    result;    // address for loads and stores.
    word_t    store_data;
    logic     is_load;
    logic     is_store;
    reg_idx_t rd;
    logic     sup;

    modport src (output valid, result, store_data, is_load, is_store, rd, sup);
    modport sink (input valid, result, store_data, is_load, is_store, rd, sup);
    modport mon (input valid, rd);
endinterface

`default_nettype wire

// File: source/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
#(
    parameter rv_pkg::word_t RESET_PC = '0
)
(
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_stall,
    input  logic          i_flush,
    input  logic          i_pc_change,
    input  rv_pkg::word_t i_branch_target,
    output rv_pkg::word_t o_imem_addr,
    input  rv_pkg::inst_t i_imem_data,
    output rv_pkg::inst_t o_inst,
    output rv_pkg::word_t o_pc
);
    import rv_pkg::*;

    word_t pc;

    assign o_imem_addr = pc;

    // a redirect wins over a stall.
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            pc <= RESET_PC;
        else if (i_pc_change)
            pc <= i_branch_target;
        else if (!i_stall)
            pc <= pc + 32'd4;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_flush)
            o_inst <= NOP_INST;    // wrong-path slot.
        else if (!i_stall)
            o_inst <= i_imem_data;
        if (!i_stall)
            o_pc <= pc;
    end

endmodule

`default_nettype wire

// File: source/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
(
    input  logic             i_clk,
    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    output rv_pkg::word_t    o_rs1_val,
    output rv_pkg::word_t    o_rs2_val,
    input  logic             i_wb_en,
    input  rv_pkg::reg_idx_t i_wb_rd,
    input  rv_pkg::word_t    i_wb_data
);
    import rv_pkg::*;

    word_t regs [1:31];    // x0 has no storage.

    always_ff @(posedge i_clk)
    begin
        if (i_wb_en && (i_wb_rd != '0))
            regs[i_wb_rd] <= i_wb_data;
    end

    // a write in flight is seen by the reader in the same cycle.
    assign o_rs1_val = (i_rs1 == '0) ? '0 :
                       (i_wb_en && (i_wb_rd == i_rs1)) ? i_wb_data : regs[i_rs1];
    assign o_rs2_val = (i_rs2 == '0) ? '0 :
                       (i_wb_en && (i_wb_rd == i_rs2)) ? i_wb_data : regs[i_rs2];

endmodule

`default_nettype wire

// File: source/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode
(
    input  logic             i_clk,
    input  logic             i_flush,
    input  logic             i_stall,
    input  rv_pkg::inst_t    i_inst,
    input  rv_pkg::word_t    i_pc,
    output rv_pkg::reg_idx_t o_rs1,
    output rv_pkg::reg_idx_t o_rs2,
    input  rv_pkg::word_t    i_rs1_val,
    input  rv_pkg::word_t    i_rs2_val,
    rv_dec_if.src            dec
);
    import rv_pkg::*;

    opcode_t  opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic     sup;
    alu_op_t  op;
    word_t    imm;
    logic     use_imm;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    logic     writes_rd;
    logic     uses_rs1;
    logic     uses_rs2;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    always_comb
    begin
        sup       = 1'b1;
        op        = ALU_ADD;
        imm       = {{20{i_inst[31]}}, i_inst[31:20]};    // i-type.
        use_imm   = 1'b1;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        writes_rd = 1'b0;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                use_imm   = 1'b0;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
                if (funct7 == 7'b0100000 && funct3 == 3'b000)
                    op = ALU_SUB;
                else if (funct7 != 7'b0000000)
                    sup = 1'b0;
                else if (funct3 == 3'b100)
                    op = ALU_XOR;
                else if (funct3 == 3'b110)
                    op = ALU_OR;
                else if (funct3 == 3'b111)
                    op = ALU_AND;
                else if (funct3 != 3'b000)
                    sup = 1'b0;
            end
            OPC_OPIMM:
            begin
                writes_rd = 1'b1;
                sup       = (funct3 == 3'b000);    // addi only.
            end
            OPC_LUI:
            begin
                op        = ALU_PASS_B;
                imm       = {i_inst[31:12], 12'b0};
                uses_rs1  = 1'b0;
                writes_rd = 1'b1;
            end
            OPC_LOAD:
            begin
                sup       = (funct3 == 3'b010);
                is_load   = sup;
                writes_rd = 1'b1;
            end
            OPC_STORE:
            begin
                imm      = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
                sup      = (funct3 == 3'b010);
                is_store = sup;
                uses_rs2 = 1'b1;
            end
            OPC_BRANCH:
            begin
                imm       = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                             i_inst[11:8], 1'b0};
                sup       = (funct3 == 3'b000);
                is_branch = sup;
                uses_rs2  = 1'b1;
            end
            default: sup = 1'b0;
        endcase
        // unsupported encodings travel as a bubble.
        if (!sup)
        begin
            writes_rd = 1'b0;
            uses_rs1  = 1'b0;
            uses_rs2  = 1'b0;
        end
    end

    assign o_rs1 = uses_rs1 ? i_inst[19:15] : '0;
    assign o_rs2 = uses_rs2 ? i_inst[24:20] : '0;

    always_ff @(posedge i_clk)
    begin
        if (i_flush)
        begin
            dec.valid     <= 1'b0;
            dec.is_load   <= 1'b0;
            dec.is_store  <= 1'b0;
            dec.is_branch <= 1'b0;
            dec.rd        <= '0;
        end
        else if (!i_stall)
        begin
            dec.valid     <= 1'b1;
            dec.is_load   <= is_load;
            dec.is_store  <= is_store;
            dec.is_branch <= is_branch;
            dec.rd        <= writes_rd ? i_inst[11:7] : '0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_stall)
        begin
            dec.op      <= op;
            dec.rs1_val <= i_rs1_val;
            dec.rs2_val <= i_rs2_val;
            dec.imm     <= imm;
            dec.use_imm <= use_imm;
            dec.pc      <= i_pc;
            dec.sup     <= sup;
        end
    end

endmodule

`default_nettype wire

// File: source/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu
(
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_stall,
    rv_dec_if.sink        dec,
    rv_exe_if.src         exe,
    output logic          o_pc_change,
    output rv_pkg::word_t o_branch_target
);
    import rv_pkg::*;

    word_t operand_b;
    word_t alu_result;

    assign operand_b = dec.use_imm ? dec.imm : dec.rs2_val;

    always_comb
    begin
        case (dec.op)
            ALU_ADD:    alu_result = dec.rs1_val + operand_b;
            ALU_SUB:    alu_result = dec.rs1_val - operand_b;
            ALU_AND:    alu_result = dec.rs1_val & operand_b;
            ALU_OR:     alu_result = dec.rs1_val | operand_b;
            ALU_XOR:    alu_result = dec.rs1_val ^ operand_b;
            ALU_PASS_B: alu_result = operand_b;
            default:    alu_result = '0;
        endcase
    end

    // beq resolves here. the flush it causes removes the branch from alu.
    assign o_pc_change     = dec.valid && dec.is_branch && (dec.rs1_val == dec.rs2_val);
    assign o_branch_target = dec.pc + dec.imm;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            exe.valid    <= 1'b0;
            exe.is_load  <= 1'b0;
            exe.is_store <= 1'b0;
        end
        else if (!i_stall)
        begin
            exe.valid    <= dec.valid;
            exe.is_load  <= dec.is_load;
            exe.is_store <= dec.is_store;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_stall)
        begin
            exe.result     <= alu_result;
            exe.store_data <= dec.rs2_val;
            exe.rd         <= dec.rd;
            exe.sup        <= dec.sup;
        end
    end

endmodule

`default_nettype wire

// File: source/rv_mem.sv
`timescale 1ns/1ps
`default_nettype none

module rv_mem
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_stall,
    rv_exe_if.sink           exe,
    output rv_pkg::word_t    o_dmem_addr,
    output rv_pkg::word_t    o_dmem_wdata,
    output logic             o_dmem_we,
    output logic             o_dmem_re,
    input  rv_pkg::word_t    i_dmem_rdata,
    output logic             o_wb_en,
    output rv_pkg::reg_idx_t o_wb_rd,
    output rv_pkg::word_t    o_wb_data,
    output logic             o_retire_sup,
    output logic             o_retire_valid
);
    import rv_pkg::*;

    // the exe register stays put while stalled, so the request is stable.
    assign o_dmem_addr  = exe.result;
    assign o_dmem_wdata = exe.store_data;
    assign o_dmem_we    = exe.valid && exe.is_store;
    assign o_dmem_re    = exe.valid && exe.is_load;

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_stall)
            o_wb_en <= 1'b0;    // no write until the access completes.
        else
            o_wb_en <= exe.valid && !exe.is_store && (exe.rd != '0);
    end

    always_ff @(posedge i_clk)
    begin
        o_wb_rd   <= exe.rd;
        o_wb_data <= exe.is_load ? i_dmem_rdata : exe.result;
    end

    assign o_retire_valid = exe.valid && !i_stall;
    assign o_retire_sup   = exe.sup;

endmodule

`default_nettype wire

// File: source/rv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_pc_change,
    input  rv_pkg::reg_idx_t i_dec_rs1,
    input  rv_pkg::reg_idx_t i_dec_rs2,
    rv_dec_if.mon            dec,
    rv_exe_if.mon            exe,
    input  logic             i_dmem_ready,
    input  logic             i_retire_valid,
    input  logic             i_retire_sup,
    output logic             o_fetch_stall,
    output logic             o_decode_flush,
    output logic             o_decode_stall,
    output logic             o_alu_flush,
    output logic             o_alu_stall,
    output logic             o_mem_stall,
    output logic             o_inv_inst
);
    import rv_pkg::*;

    logic global_flush;
    logic hazard_alu;
    logic hazard_mem;
    logic load_in_alu;
    logic decode_stall;

    // x0 never matches, since sources of zero are ignored.
    function automatic logic src_match(input reg_idx_t rs1, input reg_idx_t rs2,
                                       input reg_idx_t rd);
        return ((rs1 != '0) && (rs1 == rd)) || ((rs2 != '0) && (rs2 == rd));
    endfunction

    assign hazard_alu   = dec.valid && src_match(i_dec_rs1, i_dec_rs2, dec.rd);
    assign hazard_mem   = exe.valid && src_match(i_dec_rs1, i_dec_rs2, exe.rd);
    assign load_in_alu  = dec.valid && dec.is_load;
    assign decode_stall = hazard_alu || hazard_mem || load_in_alu || !i_dmem_ready;

    assign global_flush = i_rst || i_pc_change;

    assign o_fetch_stall  = decode_stall;
    assign o_decode_flush = global_flush;
    assign o_decode_stall = decode_stall;
    assign o_alu_flush    = global_flush || (decode_stall && i_dmem_ready);    // bubble.
    assign o_alu_stall    = !i_dmem_ready;
    assign o_mem_stall    = !i_dmem_ready;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            o_inv_inst <= 1'b0;
        else
            o_inv_inst <= i_retire_valid && !i_retire_sup;
    end

endmodule

`default_nettype wire

// File: source/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
#(
    parameter rv_pkg::word_t RESET_PC = '0
)
(
    input  logic          i_clk,
    input  logic          i_rst,
    output rv_pkg::word_t o_imem_addr,
    input  rv_pkg::inst_t i_imem_data,
    output rv_pkg::word_t o_dmem_addr,
    output rv_pkg::word_t o_dmem_wdata,
    output logic          o_dmem_we,
    output logic          o_dmem_re,
    input  rv_pkg::word_t i_dmem_rdata,
    input  logic          i_dmem_ready,
    output logic          o_inv_inst
);
    import rv_pkg::*;

    inst_t    fetch_inst;
    word_t    fetch_pc;
    reg_idx_t dec_rs1;
    reg_idx_t dec_rs2;
    word_t    rs1_val;
    word_t    rs2_val;
    logic     pc_change;
    word_t    branch_target;
    logic     fetch_stall;
    logic     decode_flush;
    logic     decode_stall;
    logic     alu_flush;
    logic     alu_stall;
    logic     mem_stall;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     retire_valid;
    logic     retire_sup;

    rv_dec_if dec_bus ();
    rv_exe_if exe_bus ();

    rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .i_clk(i_clk), .i_rst(i_rst), .i_stall(fetch_stall), .i_flush(decode_flush),
        .i_pc_change(pc_change), .i_branch_target(branch_target),
        .o_imem_addr(o_imem_addr), .i_imem_data(i_imem_data),
        .o_inst(fetch_inst), .o_pc(fetch_pc)
    );

    rv_regfile u_regfile (
        .i_clk(i_clk), .i_rs1(dec_rs1), .i_rs2(dec_rs2),
        .o_rs1_val(rs1_val), .o_rs2_val(rs2_val),
        .i_wb_en(wb_en), .i_wb_rd(wb_rd), .i_wb_data(wb_data)
    );

    rv_decode u_decode (
        .i_clk(i_clk), .i_flush(alu_flush), .i_stall(decode_stall),
        .i_inst(fetch_inst), .i_pc(fetch_pc), .o_rs1(dec_rs1), .o_rs2(dec_rs2),
        .i_rs1_val(rs1_val), .i_rs2_val(rs2_val), .dec(dec_bus.src)
    );

    rv_alu u_alu (
        .i_clk(i_clk), .i_rst(i_rst), .i_stall(alu_stall),
        .dec(dec_bus.sink), .exe(exe_bus.src),
        .o_pc_change(pc_change), .o_branch_target(branch_target)
    );

    rv_mem u_mem (
        .i_clk(i_clk), .i_rst(i_rst), .i_stall(mem_stall), .exe(exe_bus.sink),
        .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata),
        .o_dmem_we(o_dmem_we), .o_dmem_re(o_dmem_re), .i_dmem_rdata(i_dmem_rdata),
        .o_wb_en(wb_en), .o_wb_rd(wb_rd), .o_wb_data(wb_data),
        .o_retire_sup(retire_sup), .o_retire_valid(retire_valid)
    );

    rv_ctrl u_ctrl (
        .i_clk(i_clk), .i_rst(i_rst), .i_pc_change(pc_change),
        .i_dec_rs1(dec_rs1), .i_dec_rs2(dec_rs2),
        .dec(dec_bus.mon), .exe(exe_bus.mon), .i_dmem_ready(i_dmem_ready),
        .i_retire_valid(retire_valid), .i_retire_sup(retire_sup),
        .o_fetch_stall(fetch_stall), .o_decode_flush(decode_flush),
        .o_decode_stall(decode_stall), .o_alu_flush(alu_flush),
        .o_alu_stall(alu_stall), .o_mem_stall(mem_stall), .o_inv_inst(o_inv_inst)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 16
)
(
    output logic o_clk,
    output logic o_rst
);

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // reset drops on a rising edge, like every other driven input.
    initial
    begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    localparam word_t RESET_PC   = 32'h0000_0100;
    localparam int    PROG_LEN   = 60;
    localparam int    PERIOD_NS  = 4;
    localparam int    RST_CYC    = 16;
    localparam int    TIMEOUT_NS = (PROG_LEN * 20 + RST_CYC) * PERIOD_NS;

    logic  clk;
    logic  rst;
    word_t imem_addr;
    inst_t imem_data;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    logic  dmem_re;
    word_t dmem_rdata;
    logic  dmem_ready;
    logic  inv_inst;

    inst_t rom [0:PROG_LEN-1];
    word_t dmem [0:63];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t exp_load [$];
    int    exp_inv;
    int    exp_total;
    int    stores_seen = 0;
    int    loads_seen = 0;
    int    inv_seen = 0;
    int    seed = 70;

    tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RST_CYC)) u_clock (.o_clk(clk), .o_rst(rst));

    rv_core #(.RESET_PC(RESET_PC)) uut (
        .i_clk(clk), .i_rst(rst), .o_imem_addr(imem_addr), .i_imem_data(imem_data),
        .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata), .o_dmem_we(dmem_we),
        .o_dmem_re(dmem_re), .i_dmem_rdata(dmem_rdata), .i_dmem_ready(dmem_ready),
        .o_inv_inst(inv_inst)
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    function automatic word_t fill_word(input int idx);
        return (32'(idx) + 32'd1) * 32'h9e37_79b9;    // depends on every address bit.
    endfunction

    function automatic inst_t rom_read(input word_t addr);
        word_t off;
        off = addr - RESET_PC;
        if (off[1:0] == 2'b00 && off < 32'(PROG_LEN * 4))
            return rom[int'(off >> 2)];
        return NOP_INST;    // past the program the core just runs nops.
    endfunction

    function automatic reg_idx_t rand_reg(input int lo);
        return reg_idx_t'(lo + (($random(seed) & 32'h7fff_ffff) % (8 - lo)));
    endfunction

    function automatic inst_t gen_inst(input int pos);
        int       kind;
        int       skip;
        logic [11:0] ofs;
        logic [12:0] br;
        logic [2:0]  f3;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        kind = $random(seed) & 15;
        rd   = rand_reg(1);
        rs1  = rand_reg(0);
        rs2  = rand_reg(0);
        ofs  = {4'b0, 6'($random(seed)), 2'b00};    // word inside the 64-word region.
        if (pos == PROG_LEN - 1)
            return {ofs[11:5], rs2, 5'd0, 3'b010, ofs[4:0], OPC_STORE};
        if (kind >= 12 && kind <= 13 && pos >= PROG_LEN - 3)
            kind = 4;
        case (kind)
            0, 1, 2, 3:
            begin
                f3 = 3'(($random(seed) & 32'h7fff_ffff) % 5);
                case (f3)
                    3'd0:    return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
                    3'd1:    return {7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP};
                    3'd2:    return {7'b0000000, rs2, rs1, 3'b111, rd, OPC_OP};
                    3'd3:    return {7'b0000000, rs2, rs1, 3'b110, rd, OPC_OP};
                    default: return {7'b0000000, rs2, rs1, 3'b100, rd, OPC_OP};
                endcase
            end
            6:       return {20'($random(seed)), rd, OPC_LUI};
            7, 8:    return {ofs, 5'd0, 3'b010, rd, OPC_LOAD};
            9, 10, 11:
                     return {ofs[11:5], rs2, 5'd0, 3'b010, ofs[4:0], OPC_STORE};
            12, 13:
            begin
                skip = 2 + (($random(seed) & 32'h7fff_ffff) % 4);
                if (pos + skip > PROG_LEN - 1)
                    skip = PROG_LEN - 1 - pos;
                if ($random(seed) & 1)
                    rs2 = rs1;    // taken more often than not.
                br = 13'(skip * 4);
                return {br[12], br[10:5], rs2, rs1, 3'b000, br[4:1], br[11], OPC_BRANCH};
            end
            14:
            begin
                if ($random(seed) & 1)
                    return 32'hffff_ffff;
                return {7'b0000000, rs2, rs1, 3'b001, rd, OPC_OP};    // sll.
            end
            default: return {12'($random(seed)), rs1, 3'b000, rd, OPC_OPIMM};
        endcase
    endfunction

    // architectural model of the program, straight from the rv32i rules.
    function automatic void ref_run();
        word_t    regs [0:31];
        word_t    mem [0:63];
        int       idx;
        int       next;
        inst_t    inst;
        word_t    imm_i;
        word_t    imm_s;
        word_t    imm_b;
        word_t    a;
        word_t    b;
        word_t    addr;
        reg_idx_t rd;
        logic [2:0] f3;
        logic [6:0] f7;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < 64; i++)
            mem[i] = fill_word(i);
        exp_addr.delete();
        exp_data.delete();
        exp_load.delete();
        exp_inv = 0;
        idx = 0;
        while (idx < PROG_LEN)
        begin
            inst  = rom[idx];
            rd    = inst[11:7];
            f3    = inst[14:12];
            f7    = inst[31:25];
            a     = regs[inst[19:15]];
            b     = regs[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            next  = idx + 1;
            case (inst[6:0])
                OPC_OP:
                    if (f7 == 7'b0100000 && f3 == 3'b000) regs[rd] = a - b;
                    else if (f7 != 7'b0000000) exp_inv++;
                    else if (f3 == 3'b000) regs[rd] = a + b;
                    else if (f3 == 3'b100) regs[rd] = a ^ b;
                    else if (f3 == 3'b110) regs[rd] = a | b;
                    else if (f3 == 3'b111) regs[rd] = a & b;
                    else exp_inv++;
                OPC_OPIMM:
                    if (f3 == 3'b000) regs[rd] = a + imm_i;
                    else exp_inv++;
                OPC_LUI:    regs[rd] = {inst[31:12], 12'b0};
                OPC_LOAD:
                begin
                    addr = a + imm_i;
                    if (f3 == 3'b010)
                    begin
                        regs[rd] = mem[addr[7:2]];
                        exp_load.push_back(addr);
                    end
                    else
                        exp_inv++;
                end
                OPC_STORE:
                begin
                    addr = a + imm_s;
                    if (f3 == 3'b010)
                    begin
                        mem[addr[7:2]] = b;
                        exp_addr.push_back(addr);
                        exp_data.push_back(b);
                    end
                    else
                        exp_inv++;
                end
                OPC_BRANCH:
                    if (f3 != 3'b000) exp_inv++;
                    else if (a == b) next = idx + int'($signed(imm_b) >>> 2);
                default:    exp_inv++;
            endcase
            regs[0] = '0;
            idx = next;
        end
        exp_total = exp_addr.size();
    endfunction

    // memories answer combinationally.
    assign imem_data  = rom_read(imem_addr);
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    initial
    begin
        dmem_ready = 1'b1;
        for (int i = 0; i < 64; i++)
            dmem[i] <= fill_word(i);
        for (int i = 0; i < PROG_LEN; i++)
            rom[i] = gen_inst(i);
        ref_run();
    end

    always @(posedge clk)
    begin
        if (rst)
            dmem_ready <= 1'b1;
        else
            dmem_ready <= (($random(seed) & 3) != 0);    // low about a quarter of the time.
        if (!rst && dmem_we && dmem_ready)
            dmem[dmem_addr[7:2]] <= dmem_wdata;
    end

    // store, load and pulse checker.
    always @(posedge clk)
    begin
        if (!rst && dmem_we && dmem_ready)
        begin
            assert (stores_seen < exp_total)
            else stop_run("a store appeared that the program never executes");
            assert (dmem_addr == exp_addr[stores_seen])
            else stop_run($sformatf("Fail o_dmem_addr got %h expected %h",
                                    dmem_addr, exp_addr[stores_seen]));
            assert (dmem_wdata == exp_data[stores_seen])
            else stop_run($sformatf("Fail o_dmem_wdata got %h expected %h",
                                    dmem_wdata, exp_data[stores_seen]));
            stores_seen++;
        end
        if (!rst && dmem_re && dmem_ready)
        begin
            assert (loads_seen < exp_load.size())
            else stop_run("a load appeared that the program never executes");
            assert (dmem_addr == exp_load[loads_seen])
            else stop_run($sformatf("Fail o_dmem_addr got %h expected %h",
                                    dmem_addr, exp_load[loads_seen]));
            loads_seen++;
        end
        if (!rst && inv_inst)
            inv_seen++;
    end

    initial
    begin
        #(TIMEOUT_NS);
        stop_run("timeout, the program did not finish");
    end

    initial
    begin
        @(negedge rst);
        @(posedge clk);
        assert (imem_addr == RESET_PC)
        else stop_run($sformatf("Fail o_imem_addr got %h expected %h", imem_addr, RESET_PC));
        assert ({dmem_we, dmem_re, inv_inst} == 3'b000)
        else stop_run($sformatf("Fail {o_dmem_we, o_dmem_re, o_inv_inst} got %h expected 0",
                                {dmem_we, dmem_re, inv_inst}));
        wait (stores_seen == exp_total);
        repeat (4) @(posedge clk);    // let the last pulses land.
        assert (loads_seen == exp_load.size())
        else stop_run($sformatf("Fail o_dmem_re count got %h expected %h",
                                loads_seen, exp_load.size()));
        assert (inv_seen == exp_inv)
        else stop_run($sformatf("Fail o_inv_inst count got %h expected %h", inv_seen, exp_inv));
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
source/rv_pkg.sv
source/rv_stage_if.sv
source/rv_fetch.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_alu.sv
source/rv_mem.sv
source/rv_ctrl.sv
source/rv_core.sv
testbench/tb_clock.sv
testbench/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
    --top-module tb_rv_core -o tb_rv_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_rv_core > "$LOG" 2>&1
RUN_STATUS=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
    exit 1
fi
if [ $RUN_STATUS -ne 0 ]; then
    echo "simulation exited with status $RUN_STATUS"
    exit 1
fi
exit 0
